// ==== run_sim.sh ====
#!/bin/sh
# verilator build and run, result comes from the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

# a build or run that dies early is logged as a failure too
verilator --binary --timing --assert -f sources.f --top-module tb_mem_hierarchy \
    > sim.log 2>&1 \
    && ./obj_dir/Vtb_mem_hierarchy >> sim.log 2>&1 \
    || echo "Test failed" >> sim.log

cat sim.log
grep -q "Test failed" sim.log && exit 1 || exit 0

// ==== source/arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module arbiter
    import lc3b_types_pkg::*;
(
    input  logic          clk,
    input  logic          i_rst_n,

    // requester 0, instruction cache
    input  logic          i_req0_read,
    input  logic          i_req0_write,
    input  lc3b_word      i_req0_address,
    input  lc3b_cacheline i_req0_wdata,
    output logic          o_req0_resp,
    output lc3b_cacheline o_req0_rdata,

    // requester 1, eviction buffer
    input  logic          i_req1_read,
    input  logic          i_req1_write,
    input  lc3b_word      i_req1_address,
    input  lc3b_cacheline i_req1_wdata,
    output logic          o_req1_resp,
    output lc3b_cacheline o_req1_rdata,

    // physical memory port
    output logic          o_pmem_read,
    output logic          o_pmem_write,
    output lc3b_word      o_pmem_address,
    output lc3b_cacheline o_pmem_wdata,
    input  logic          i_pmem_resp,
    input  lc3b_cacheline i_pmem_rdata
);

    localparam logic [1:0] ST_IDLE  = 2'd0;
    localparam logic [1:0] ST_BUSY0 = 2'd1;
    localparam logic [1:0] ST_BUSY1 = 2'd2;

    logic [1:0] state;
    logic       last1;      // requester 1 got the previous grant
    logic       req0;
    logic       req1;
    logic       pick1;
    logic       busy0;
    logic       busy1;

    assign req0 = i_req0_read | i_req0_write;
    assign req1 = i_req1_read | i_req1_write;

    // both waiting, whoever was not served last
    assign pick1 = req1 && (!req0 || !last1);

    assign busy0 = (state == ST_BUSY0);
    assign busy1 = (state == ST_BUSY1);

    // port only driven once granted, one cycle after the request shows up
    assign o_pmem_read    = (busy0 & i_req0_read) | (busy1 & i_req1_read);
    assign o_pmem_write   = (busy0 & i_req0_write) | (busy1 & i_req1_write);
    assign o_pmem_address = busy1 ? i_req1_address : i_req0_address;
    assign o_pmem_wdata   = busy1 ? i_req1_wdata : i_req0_wdata;

    // resp passes straight through to the owner only
    assign o_req0_resp  = busy0 & i_pmem_resp;
    assign o_req1_resp  = busy1 & i_pmem_resp;
    assign o_req0_rdata = busy0 ? i_pmem_rdata : '0;
    assign o_req1_rdata = busy1 ? i_pmem_rdata : '0;

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state <= ST_IDLE;
            last1 <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (req0 || req1) begin
                        state <= pick1 ? ST_BUSY1 : ST_BUSY0;
                        last1 <= pick1;
                    end
                end
                ST_BUSY0, ST_BUSY1: begin
                    if (i_pmem_resp) begin
                        state <= ST_IDLE;            // owner drops or re-requests next cycle
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule : arbiter

`default_nettype wire

// ==== source/eviction_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lc3b_defines.svh"

module eviction_buffer
    import lc3b_types_pkg::*;
(
    input  logic          clk,
    input  logic          i_rst_n,

    // upstream, from the data cache
    input  logic          i_buf_read,
    input  logic          i_buf_write,
    input  lc3b_word      i_buf_address,
    input  lc3b_cacheline i_buf_wdata,
    output logic          o_buf_resp,
    output lc3b_cacheline o_buf_rdata,

    // downstream, toward the arbiter
    output logic          o_mem_read,
    output logic          o_mem_write,
    output lc3b_word      o_mem_address,
    output lc3b_cacheline o_mem_wdata,
    input  logic          i_mem_resp,
    input  lc3b_cacheline i_mem_rdata
);

    logic          full;        // one line waiting to drain
    logic          resp_q;      // local answer, write taken or read matched
    lc3b_line_addr hold_addr;
    lc3b_cacheline hold_line;
    lc3b_line_addr req_line;

    logic wr_accept;
    logic rd_match;
    logic fwd_read;

    // upstream always asks for whole lines but clear the offset anyway
    assign req_line = {i_buf_address[`LC3B_WORD_BITS-1:`LC3B_OFFSET_BITS],
                       {`LC3B_OFFSET_BITS{1'b0}}};

    // resp_q blocks the request still held in its own resp cycle
    assign wr_accept = i_buf_write && !full && !resp_q;
    assign rd_match  = i_buf_read && full && !resp_q && (req_line == hold_addr);

    // miss reads only pass once the held line is gone, keeps memory order
    assign fwd_read  = i_buf_read && !full && !resp_q;

    // drain runs whenever full, reads go down only when empty
    assign o_mem_write   = full;
    assign o_mem_read    = fwd_read;
    assign o_mem_address = full ? hold_addr : i_buf_address;
    assign o_mem_wdata   = hold_line;

    assign o_buf_resp  = resp_q | (fwd_read & i_mem_resp);
    assign o_buf_rdata = resp_q ? hold_line : i_mem_rdata;   // held line for a match

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            full   <= 1'b0;
            resp_q <= 1'b0;
        end else begin
            resp_q <= wr_accept | rd_match;
            if (wr_accept) begin
                full <= 1'b1;
            end else if (full && i_mem_resp) begin
                full <= 1'b0;                        // drain done
            end
        end
    end

    // line payload, only replaced on a new write-back
    always_ff @(posedge clk) begin
        if (wr_accept) begin
            hold_addr <= req_line;
            hold_line <= i_buf_wdata;
        end
    end

endmodule : eviction_buffer

`default_nettype wire

// ==== source/l1_cache.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lc3b_defines.svh"

module l1_cache
    import lc3b_types_pkg::*;
(
    input  logic          clk,
    input  logic          i_rst_n,

    // cpu side, word sized
    input  logic          i_mem_read,
    input  logic          i_mem_write,
    input  lc3b_mem_wmask i_mem_byte_enable,
    input  lc3b_word      i_mem_address,
    input  lc3b_word      i_mem_wdata,
    output logic          o_mem_resp,
    output lc3b_word      o_mem_rdata,

    // lower side, one line per transfer
    input  logic          i_lower_resp,
    input  lc3b_cacheline i_lower_rdata,
    output logic          o_lower_read,
    output logic          o_lower_write,
    output lc3b_word      o_lower_address,
    output lc3b_cacheline o_lower_wdata
);

    localparam logic [1:0] ST_IDLE      = 2'd0;   // tag compare happens here
    localparam logic [1:0] ST_WRITEBACK = 2'd1;   // pushing dirty victim down
    localparam logic [1:0] ST_FETCH     = 2'd2;   // reading the missing line
    localparam logic [1:0] ST_RESUME    = 2'd3;   // one bubble, then replay as hit

    localparam int TAG_LSB = `LC3B_OFFSET_BITS + `LC3B_INDEX_BITS;

    logic [1:0] state;
    logic [1:0] state_nxt;

    // per set storage
    logic [`LC3B_TAG_BITS-1:0] tag_arr [`LC3B_L1_SETS];
    logic [`LC3B_L1_SETS-1:0]  valid_arr;
    logic [`LC3B_L1_SETS-1:0]  dirty_arr;
    lc3b_cacheline             data_arr [`LC3B_L1_SETS];

    // address fields
    logic [`LC3B_TAG_BITS-1:0]     req_tag;
    logic [`LC3B_INDEX_BITS-1:0]   req_idx;
    logic [`LC3B_OFFSET_BITS-2:0]  req_word;   // byte offset minus the byte bit

    logic          req_any;
    logic          accept;
    logic          hit;
    logic          do_access;
    logic          do_write;
    logic          fill;
    lc3b_cacheline cur_line;
    lc3b_cacheline merged_line;
    lc3b_word      merged_word;

    assign req_tag  = i_mem_address[`LC3B_WORD_BITS-1:TAG_LSB];
    assign req_idx  = i_mem_address[TAG_LSB-1:`LC3B_OFFSET_BITS];
    assign req_word = i_mem_address[`LC3B_OFFSET_BITS-1:1];

    assign req_any  = i_mem_read | i_mem_write;
    assign cur_line = data_arr[req_idx];
    assign hit      = valid_arr[req_idx] && (tag_arr[req_idx] == req_tag);

    // while resp is up the cpu still holds the same request, skip that cycle
    assign accept    = (state == ST_IDLE) && req_any && !o_mem_resp;
    assign do_access = accept && hit;
    assign do_write  = do_access && i_mem_write;
    assign fill      = (state == ST_FETCH) && i_lower_resp;

    // byte merge on the addressed word
    always_comb begin
        merged_word = cur_line.words[req_word];
        if (i_mem_write && i_mem_byte_enable[0]) begin
            merged_word[7:0] = i_mem_wdata[7:0];
        end
        if (i_mem_write && i_mem_byte_enable[1]) begin
            merged_word[15:8] = i_mem_wdata[15:8];
        end
        merged_line                = cur_line;
        merged_line.words[req_word] = merged_word;   // drop it back into the line
    end

    // miss sequencing
    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: begin
                if (accept && !hit) begin
                    // dirty victim has to leave first
                    if (valid_arr[req_idx] && dirty_arr[req_idx]) begin
                        state_nxt = ST_WRITEBACK;
                    end else begin
                        state_nxt = ST_FETCH;
                    end
                end
            end
            ST_WRITEBACK: begin
                if (i_lower_resp) begin
                    state_nxt = ST_FETCH;
                end
            end
            ST_FETCH: begin
                if (i_lower_resp) begin
                    state_nxt = ST_RESUME;
                end
            end
            ST_RESUME: state_nxt = ST_IDLE;   // idle sees the new line and hits
            default:   state_nxt = ST_IDLE;
        endcase
    end

    // lower request comes straight from state
    assign o_lower_read  = (state == ST_FETCH);
    assign o_lower_write = (state == ST_WRITEBACK);
    assign o_lower_wdata = cur_line;                 // victim line, only used in writeback

    always_comb begin
        if (state == ST_WRITEBACK) begin
            // victim address rebuilt from the stored tag
            o_lower_address = {tag_arr[req_idx], req_idx, {`LC3B_OFFSET_BITS{1'b0}}};
        end else begin
            o_lower_address = {req_tag, req_idx, {`LC3B_OFFSET_BITS{1'b0}}};
        end
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state      <= ST_IDLE;
            valid_arr  <= '0;
            dirty_arr  <= '0;
            o_mem_resp <= 1'b0;
        end else begin
            state      <= state_nxt;
            o_mem_resp <= do_access;                 // hit answers at the next edge
            if (fill) begin
                valid_arr[req_idx] <= 1'b1;
                dirty_arr[req_idx] <= 1'b0;          // fresh from below, clean
            end else if (do_write) begin
                dirty_arr[req_idx] <= 1'b1;
            end
        end
    end

    // tags, lines and read data
    always_ff @(posedge clk) begin
        if (fill) begin
            tag_arr[req_idx]  <= req_tag;
            data_arr[req_idx] <= i_lower_rdata;
        end else if (do_write) begin
            data_arr[req_idx] <= merged_line;
        end
        if (do_access) begin
            o_mem_rdata <= merged_word;              // old word on reads, merged on writes
        end
    end

endmodule : l1_cache

`default_nettype wire

// ==== source/lc3b_defines.svh ====
`ifndef LC3B_DEFINES_SVH
`define LC3B_DEFINES_SVH

// word and line shape
`define LC3B_WORD_BITS    16
`define LC3B_LINE_WORDS   8
`define LC3B_LINE_BITS    (`LC3B_WORD_BITS * `LC3B_LINE_WORDS)   // 128 bit line
`define LC3B_WMASK_BITS   2                                      // one enable per byte

// l1 geometry, direct mapped
`define LC3B_L1_SETS      8
`define LC3B_OFFSET_BITS  4                                      // byte offset in line
`define LC3B_INDEX_BITS   3

// whatever is left of the 16 bit address is tag
`define LC3B_TAG_BITS     (`LC3B_WORD_BITS - `LC3B_INDEX_BITS - `LC3B_OFFSET_BITS)

`endif

// ==== source/lc3b_types_pkg.sv ====
`default_nettype none

`include "lc3b_defines.svh"

package lc3b_types_pkg;

    // one data word, also the full byte address
    typedef logic [`LC3B_WORD_BITS-1:0] lc3b_word;

    // byte enables, bit 0 is the low byte
    typedef logic [`LC3B_WMASK_BITS-1:0] lc3b_mem_wmask;

    // address with the offset bits forced to zero
    typedef logic [`LC3B_WORD_BITS-1:0] lc3b_line_addr;

    // one cache line, two ways to look at it
    // memory side moves flat, cache datapath picks words
    // word 0 lives in bits 15:0
    typedef union packed {
        logic [`LC3B_LINE_BITS-1:0]         flat;
        lc3b_word [`LC3B_LINE_WORDS-1:0]    words;
    } lc3b_cacheline;

endpackage : lc3b_types_pkg

`default_nettype wire

// ==== source/mem_hierarchy.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_hierarchy
    import lc3b_types_pkg::*;
(
    input  logic          clk,
    input  logic          i_rst_n,

    // cpu instruction port
    input  logic          i_imem_read,
    input  logic          i_imem_write,
    input  lc3b_mem_wmask i_imem_byte_enable,
    input  lc3b_word      i_imem_address,
    input  lc3b_word      i_imem_wdata,
    output logic          o_imem_resp,
    output lc3b_word      o_imem_rdata,

    // cpu data port
    input  logic          i_dmem_read,
    input  logic          i_dmem_write,
    input  lc3b_mem_wmask i_dmem_byte_enable,
    input  lc3b_word      i_dmem_address,
    input  lc3b_word      i_dmem_wdata,
    output logic          o_dmem_resp,
    output lc3b_word      o_dmem_rdata,

    // physical memory
    output logic          o_pmem_read,
    output logic          o_pmem_write,
    output lc3b_word      o_pmem_address,
    output lc3b_cacheline o_pmem_wdata,
    input  logic          i_pmem_resp,
    input  lc3b_cacheline i_pmem_rdata
);

    // i_cache to arbiter port 0
    logic          ic_read, ic_write, ic_resp;
    lc3b_word      ic_address;
    lc3b_cacheline ic_wdata, ic_rdata;

    // d_cache to eviction buffer
    logic          dc_read, dc_write, dc_resp;
    lc3b_word      dc_address;
    lc3b_cacheline dc_wdata, dc_rdata;

    // eviction buffer to arbiter port 1
    logic          eb_read, eb_write, eb_resp;
    lc3b_word      eb_address;
    lc3b_cacheline eb_wdata, eb_rdata;

    l1_cache i_cache (
        .clk,
        .i_rst_n,
        .i_mem_read(i_imem_read), .i_mem_write(i_imem_write),
        .i_mem_byte_enable(i_imem_byte_enable),
        .i_mem_address(i_imem_address), .i_mem_wdata(i_imem_wdata),
        .o_mem_resp(o_imem_resp), .o_mem_rdata(o_imem_rdata),
        .i_lower_resp(ic_resp), .i_lower_rdata(ic_rdata),
        .o_lower_read(ic_read), .o_lower_write(ic_write),
        .o_lower_address(ic_address), .o_lower_wdata(ic_wdata)
    );

    l1_cache d_cache (
        .clk,
        .i_rst_n,
        .i_mem_read(i_dmem_read), .i_mem_write(i_dmem_write),
        .i_mem_byte_enable(i_dmem_byte_enable),
        .i_mem_address(i_dmem_address), .i_mem_wdata(i_dmem_wdata),
        .o_mem_resp(o_dmem_resp), .o_mem_rdata(o_dmem_rdata),
        .i_lower_resp(dc_resp), .i_lower_rdata(dc_rdata),   // write-backs land in the buffer
        .o_lower_read(dc_read), .o_lower_write(dc_write),
        .o_lower_address(dc_address), .o_lower_wdata(dc_wdata)
    );

    eviction_buffer evict_buf (
        .clk,
        .i_rst_n,
        .i_buf_read(dc_read), .i_buf_write(dc_write),
        .i_buf_address(dc_address), .i_buf_wdata(dc_wdata),
        .o_buf_resp(dc_resp), .o_buf_rdata(dc_rdata),
        .o_mem_read(eb_read), .o_mem_write(eb_write),
        .o_mem_address(eb_address), .o_mem_wdata(eb_wdata),
        .i_mem_resp(eb_resp), .i_mem_rdata(eb_rdata)
    );

    arbiter arbiter_inst (
        .clk,
        .i_rst_n,
        .i_req0_read(ic_read), .i_req0_write(ic_write),           // instruction side
        .i_req0_address(ic_address), .i_req0_wdata(ic_wdata),
        .o_req0_resp(ic_resp), .o_req0_rdata(ic_rdata),
        .i_req1_read(eb_read), .i_req1_write(eb_write),           // data side via buffer
        .i_req1_address(eb_address), .i_req1_wdata(eb_wdata),
        .o_req1_resp(eb_resp), .o_req1_rdata(eb_rdata),
        .o_pmem_read, .o_pmem_write, .o_pmem_address, .o_pmem_wdata,
        .i_pmem_resp, .i_pmem_rdata
    );

endmodule : mem_hierarchy

`default_nettype wire

// ==== sources.f ====
+incdir+source
source/lc3b_types_pkg.sv
source/l1_cache.sv
source/eviction_buffer.sv
source/arbiter.sv
source/mem_hierarchy.sv
verification/pmem_model.sv
verification/tb_mem_hierarchy.sv

// ==== verification/pmem_model.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lc3b_defines.svh"

module pmem_model
    import lc3b_types_pkg::*;
(
    input  logic          clk,
    input  logic          i_rst_n,
    input  logic          i_read,
    input  logic          i_write,
    input  lc3b_word      i_address,
    input  lc3b_cacheline i_wdata,
    output logic          o_resp,
    output lc3b_cacheline o_rdata
);

    localparam int WORDS = 32768;   // 64 KB as 16 bit words

    lc3b_word mem    [WORDS];       // what memory really holds
    lc3b_word shadow [WORDS];       // what the cpu should see, kept up by the testbench

    logic          busy;
    int            delay;
    logic [14:0]   widx;
    lc3b_cacheline line_tmp;

    // every word starts as its own byte address xor 5a5a
    initial begin
        for (int i = 0; i < WORDS; i++) begin
            mem[i]    = lc3b_word'(i * 2) ^ 16'h5a5a;
            shadow[i] = lc3b_word'(i * 2) ^ 16'h5a5a;
        end
    end

    always @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_resp  <= 1'b0;
            o_rdata <= '0;
            busy    <= 1'b0;
            delay   <= 0;
        end else begin
            o_resp <= 1'b0;
            if (busy) begin
                if (delay == 0) begin
                    // whole line moves at once
                    for (int w = 0; w < `LC3B_LINE_WORDS; w++) begin
                        widx = {i_address[15:4], w[2:0]};
                        if (i_write) begin
                            mem[widx] = i_wdata.words[w];
                        end
                        line_tmp.words[w] = mem[widx];
                    end
                    o_rdata <= line_tmp;
                    o_resp  <= 1'b1;
                    busy    <= 1'b0;
                end else begin
                    delay <= delay - 1;
                end
            end else if ((i_read || i_write) && !o_resp) begin
                busy  <= 1'b1;                       // request still held in resp cycle is skipped
                delay <= $urandom_range(3, 0);       // 1 to 4 cycles until resp
            end
        end
    end

endmodule : pmem_model

`default_nettype wire

// ==== verification/tb_mem_hierarchy.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_mem_hierarchy
    import lc3b_types_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 20000;    // about ten times the whole run
    localparam int RANDOM_OPS     = 300;
    localparam bit IPORT = 1'b0;
    localparam bit DPORT = 1'b1;
    localparam bit RD    = 1'b0;
    localparam bit WR    = 1'b1;

    logic          clk;
    logic          rst_n;
    logic          imem_read, imem_write, imem_resp;
    logic          dmem_read, dmem_write, dmem_resp;
    lc3b_mem_wmask imem_be, dmem_be;
    lc3b_word      imem_addr, imem_wdata, imem_rdata;
    lc3b_word      dmem_addr, dmem_wdata, dmem_rdata;
    logic          pmem_read, pmem_write, pmem_resp;
    lc3b_word      pmem_addr;
    lc3b_cacheline pmem_wdata, pmem_rdata;

    int errors;
    int checks;
    int cycles;
    int xfers;       // memory transfers seen so far
    int lat, used, lat2, used2;
    logic [31:0] rnd;
    lc3b_word    addr;

    mem_hierarchy dut0 (
        .clk, .i_rst_n(rst_n),
        .i_imem_read(imem_read), .i_imem_write(imem_write), .i_imem_byte_enable(imem_be),
        .i_imem_address(imem_addr), .i_imem_wdata(imem_wdata),
        .o_imem_resp(imem_resp), .o_imem_rdata(imem_rdata),
        .i_dmem_read(dmem_read), .i_dmem_write(dmem_write), .i_dmem_byte_enable(dmem_be),
        .i_dmem_address(dmem_addr), .i_dmem_wdata(dmem_wdata),
        .o_dmem_resp(dmem_resp), .o_dmem_rdata(dmem_rdata),
        .o_pmem_read(pmem_read), .o_pmem_write(pmem_write), .o_pmem_address(pmem_addr),
        .o_pmem_wdata(pmem_wdata), .i_pmem_resp(pmem_resp), .i_pmem_rdata(pmem_rdata)
    );

    pmem_model pmem0 (
        .clk, .i_rst_n(rst_n),
        .i_read(pmem_read), .i_write(pmem_write), .i_address(pmem_addr),
        .i_wdata(pmem_wdata), .o_resp(pmem_resp), .o_rdata(pmem_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;                       // 4 ns period
    end

    always @(posedge clk) begin
        if (pmem_resp) begin
            xfers++;
        end
    end

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("ERROR %s: expected %0h, actual %0h", name, exp, act);
        end
    endtask

    task automatic check_condition(input bit ok, input string what);
        checks++;
        assert (ok) else begin
            errors++;
            $display("check failed: %s", what);
        end
    endtask

    // one cpu access, held until resp, rdata checked against the shadow
    task automatic access(input string name, input bit dport, input bit wr,
                          input lc3b_mem_wmask be, input lc3b_word a, input lc3b_word wdata,
                          output int lat_o, output int used_o);
        lc3b_word    exp;
        lc3b_word    rd;
        logic [14:0] widx;
        int          start;
        widx  = a[15:1];
        start = xfers;
        lat_o = 0;
        if (dport) begin
            dmem_addr  = a;
            dmem_wdata = wdata;
            dmem_be    = be;
            dmem_read  = !wr;
            dmem_write = wr;
        end else begin
            imem_addr  = a;
            imem_wdata = wdata;
            imem_be    = be;
            imem_read  = !wr;
            imem_write = wr;
        end
        do begin
            @(posedge clk);
            #1;
            lat_o++;
        end while (!(dport ? dmem_resp : imem_resp));
        rd     = dport ? dmem_rdata : imem_rdata;
        used_o = xfers - start;
        exp    = pmem0.shadow[widx];
        if (wr) begin
            if (be[0]) exp[7:0] = wdata[7:0];        // byte merge
            if (be[1]) exp[15:8] = wdata[15:8];
            pmem0.shadow[widx] = exp;
        end
        check_value(name, 32'(exp), 32'(rd));
        @(posedge clk);                              // hold through the resp cycle
        #1;
        if (dport) begin
            dmem_read  = 1'b0;
            dmem_write = 1'b0;
        end else begin
            imem_read  = 1'b0;
            imem_write = 1'b0;
        end
    endtask

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("run hit the cycle limit, the DUT stopped answering");
        $display("checks: %0d, errors: %0d", checks, errors);
        $display("Test failed");
        $finish;
    end

    initial begin
        void'($urandom(32'hf0b8cdc6));
        errors     = 0;
        checks     = 0;
        rst_n      = 1'b0;
        imem_read  = 1'b0;
        imem_write = 1'b0;
        imem_be    = 2'b00;
        imem_addr  = '0;
        imem_wdata = '0;
        dmem_read  = 1'b0;
        dmem_write = 1'b0;
        dmem_be    = 2'b00;
        dmem_addr  = '0;
        dmem_wdata = '0;
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // quiet after reset
        repeat (4) begin
            @(posedge clk);
            #1;
            check_condition(!pmem_read && !pmem_write && !imem_resp && !dmem_resp,
                            "memory or resp activity after reset with no request");
        end

        // cold reads, then hits in the same line
        access("cold read imem", IPORT, RD, 2'b00, 16'h2000, 16'h0000, lat, used);
        check_condition(lat > 1, "cold imem read answered like a hit");
        access("repeat read imem", IPORT, RD, 2'b00, 16'h200e, 16'h0000, lat, used);
        check_value("hit latency imem", 32'd1, lat);
        access("cold read dmem", DPORT, RD, 2'b00, 16'h4000, 16'h0000, lat, used);
        check_condition(lat > 1, "cold dmem read answered like a hit");
        access("repeat read dmem", DPORT, RD, 2'b00, 16'h4006, 16'h0000, lat, used);
        check_value("hit latency dmem", 32'd1, lat);

        // every byte enable, each read back
        for (int b = 0; b < 4; b++) begin
            access("masked write", DPORT, WR, 2'(b), 16'h4010, 16'h1234 + 16'(b), lat, used);
            access("masked readback", DPORT, RD, 2'b00, 16'h4010, 16'h0000, lat, used);
        end

        // dirty evictions, 0x40a0 shares an index with 0x4020
        access("dirty write A", DPORT, WR, 2'b11, 16'h4020, 16'hbeef, lat, used);
        access("conflict read B", DPORT, RD, 2'b00, 16'h40a0, 16'h0000, lat, used);
        access("dirty write B", DPORT, WR, 2'b11, 16'h40a0, 16'hcafe, lat, used);
        access("reread A", DPORT, RD, 2'b00, 16'h4020, 16'h0000, lat, used);   // B in flight
        access("reread B", DPORT, RD, 2'b00, 16'h40a0, 16'h0000, lat, used);
        check_value("memory after dmem evict A", 32'hbeef, 32'(pmem0.mem[15'h2010]));
        check_value("memory after dmem evict B", 32'hcafe, 32'(pmem0.mem[15'h2050]));
        access("imem write", IPORT, WR, 2'b11, 16'h2030, 16'hd00d, lat, used);
        access("imem conflict read", IPORT, RD, 2'b00, 16'h20b0, 16'h0000, lat, used);
        check_value("memory after imem evict", 32'hd00d, 32'(pmem0.mem[15'h1018]));

        // both ports miss together
        fork
            access("parallel imem", IPORT, RD, 2'b00, 16'h2200, 16'h0000, lat, used);
            access("parallel dmem", DPORT, RD, 2'b00, 16'h4200, 16'h0000, lat2, used2);
        join
        check_condition(used <= 2, "imem miss waited for more than two memory transfers");
        check_condition(used2 <= 2, "dmem miss waited for more than two memory transfers");

        // random traffic, separate 512 byte windows per port
        for (int n = 0; n < RANDOM_OPS; n++) begin
            rnd  = $urandom;
            addr = (rnd[0] ? 16'h4000 : 16'h2000) | {7'd0, rnd[11:4], 1'b0};
            access($sformatf("random op %0d", n), rnd[0], rnd[1], rnd[3:2], addr,
                   rnd[31:16], lat, used);
        end

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule : tb_mem_hierarchy

`default_nettype wire
